//--- leg_shift_pkg.sv
// ====================
// shared types and sizes for the operand-2 shifter pipeline
// shift types, shift field views and stage bundles
// ====================
`default_nettype none

package leg_shift_pkg;

  localparam int word_w  = 32;  // datapath width
  localparam int shamt_w = 5;   // rotate / mask amount
  localparam int amt_w   = 8;   // register shift amount, low byte of rs
  localparam int sel5_w  = 5;   // first rank, rotate 0..4
  localparam int sel8_w  = 8;   // second rank, rotate by 0,4,..,28

  typedef enum logic [1:0] {
    lsl = 2'b00,
    lsr = 2'b01,
    asr = 2'b10,
    ror = 2'b11
  } sh_type_e;

  // shift field as it sits in instr[11:4]
  typedef struct packed {
    logic [shamt_w-1:0] imm5;
    sh_type_e           sh_type;
    logic               by_reg;   // clear here
  } imm_shift_t;

  typedef struct packed {
    logic [3:0] rs_idx;   // register holding the amount
    logic       zero;     // always 0 in a legal encoding
    sh_type_e   sh_type;
    logic       by_reg;   // set here
  } reg_shift_t;

  // same byte, two readings, picked by by_reg
  typedef union packed {
    imm_shift_t imm;
    reg_shift_t rgs;
  } shift_field_u;

  typedef enum logic [2:0] {
    c_keep,     // carry flag passes through
    src_a0,
    src_a31,
    src_rot0,
    src_rot31,
    src_zero
  } carry_src_e;

  typedef struct packed {
    logic              valid;
    logic [word_w-1:0] a;
    shift_field_u      field;
    logic [amt_w-1:0]  rs_amt;   // rs[7:0], read out by the register file
    logic              c_in;     // current C flag
  } shift_op_t;

  // stage 1 -> stage 2
  typedef struct packed {
    logic               valid;
    logic [word_w-1:0]  a;
    logic [shamt_w-1:0] shamt;
    logic               longshift;
    logic [sel5_w-1:0]  shctl_5;   // one-hot
    logic [sel8_w-1:0]  shctl_8;   // one-hot
    logic               rrx_in;
    logic               left;
    logic               shift;
    logic               arith;
    carry_src_e         carry_src;
    logic               c_in;
  } shift_ctl_t;

  // stage 2 -> stage 3
  typedef struct packed {
    logic               valid;
    logic [word_w-1:0]  rot;
    logic               a31;
    logic [shamt_w-1:0] shamt;
    logic               longshift;
    logic               left;
    logic               shift;
    logic               arith;
    logic               a0;
    logic               rot0;
    logic               rot31;
    carry_src_e         carry_src;
    logic               c_in;
  } rot_word_t;

  typedef struct packed {
    logic              valid;
    logic [word_w-1:0] y;
    logic              c_out;
  } shift_res_t;

endpackage

`default_nettype wire

//--- shift_decode.sv
// ====================
// stage 1 of the shifter pipeline
// decodes shift field and amount into rotate selects, mask controls
// and carry source, then registers them
// ====================
`default_nettype none

module shift_decode (
  input  wire                       clk,
  input  wire                       reset,
  input  leg_shift_pkg::shift_op_t  op,
  output leg_shift_pkg::shift_ctl_t ctl
);
  import leg_shift_pkg::*;

  logic               by_reg;
  sh_type_e           sh_type;
  logic [amt_w-1:0]   amt;        // effective amount before special cases
  logic               amt_zero;
  logic [shamt_w-1:0] k;          // rotate amount
  logic               long_sh;
  logic               do_shift;
  logic               rrx;
  carry_src_e         csrc;
  logic [2:0]         lo_sel, hi_sel;
  shift_ctl_t         ctl_d;

  // by_reg and type sit at the same place in both views
  assign by_reg   = op.field.rgs.by_reg;
  assign sh_type  = op.field.rgs.sh_type;
  assign amt      = by_reg ? op.rs_amt : amt_w'(op.field.imm.imm5);
  assign amt_zero = (amt == '0);

  always_comb begin
    k        = amt[shamt_w-1:0];
    long_sh  = 1'b0;
    do_shift = 1'b0;
    rrx      = 1'b0;
    csrc     = c_keep;
    unique case (sh_type)
      lsl: begin
        if (amt_zero) begin
          csrc = c_keep;                // no shift at all
        end else if (amt < amt_w'(word_w)) begin
          do_shift = 1'b1;
          csrc     = src_rot0;          // last bit out of the top lands in rot[0]
        end else begin
          do_shift = 1'b1;
          long_sh  = 1'b1;
          csrc     = (amt == amt_w'(word_w)) ? src_a0 : src_zero;
        end
      end
      lsr, asr: begin
        if (amt_zero && by_reg) begin
          csrc = c_keep;
        end else if (amt_zero || amt >= amt_w'(word_w)) begin
          // immediate #0 encodes a shift of 32
          do_shift = 1'b1;
          long_sh  = 1'b1;
          if (sh_type == asr || amt_zero || amt == amt_w'(word_w)) begin
            csrc = src_a31;
          end else begin
            csrc = src_zero;            // lsr past 32
          end
        end else begin
          do_shift = 1'b1;
          csrc     = src_rot31;         // a[k-1] ends up at the top
        end
      end
      ror: begin
        if (amt_zero && !by_reg) begin
          rrx  = 1'b1;                  // ror #0 is rrx
          k    = shamt_w'(1);
          csrc = src_a0;
        end else if (amt_zero) begin
          csrc = c_keep;
        end else if (k == '0) begin
          csrc = src_a31;               // nonzero multiple of 32
        end else begin
          csrc = src_rot31;
        end
      end
    endcase

    // left by k is right by 32-k, i.e. ~k + 1 split over the two ranks
    if (sh_type == lsl) begin
      lo_sel = {1'b0, ~k[1:0]} + 3'd1;  // 1..4, slot 4 takes the carry of the +1
      hi_sel = ~k[4:2];
    end else begin
      lo_sel = {1'b0, k[1:0]};
      hi_sel = k[4:2];
    end

    ctl_d.valid     = op.valid;
    ctl_d.a         = op.a;
    ctl_d.shamt     = long_sh ? '0 : k;
    ctl_d.longshift = long_sh;
    ctl_d.shctl_5   = sel5_w'(1) << lo_sel;
    ctl_d.shctl_8   = sel8_w'(1) << hi_sel;
    ctl_d.rrx_in    = rrx ? op.c_in : op.a[0];  // c flag only for rrx
    ctl_d.left      = (sh_type == lsl);
    ctl_d.shift     = do_shift;
    ctl_d.arith     = (sh_type == asr);
    ctl_d.carry_src = csrc;
    ctl_d.c_in      = op.c_in;
  end

  always_ff @(posedge clk) begin
    ctl <= ctl_d;
    if (reset) begin
      ctl.valid <= 1'b0;  // payload left as is
    end
  end

endmodule

`default_nettype wire

//--- barrel_shifter.sv
// ====================
// stage 2 of the shifter pipeline
// 5:1 then 8:1 one-hot rotate network, registers rotated word and carry taps
// ====================
`default_nettype none

module barrel_shifter (
  input  wire                       clk,
  input  wire                       reset,
  input  leg_shift_pkg::shift_ctl_t ctl,
  output leg_shift_pkg::rot_word_t  rw
);
  import leg_shift_pkg::*;

  logic [word_w-1:0] a;
  logic [word_w-1:0] x;     // after first rank
  logic [word_w-1:0] rot;   // after second rank
  rot_word_t         rw_d;

  assign a = ctl.a;

  // first rank: ror 0..3, plus 4 for the +1 of a left shift
  always_comb begin
    casez (ctl.shctl_5)
      5'b????1: x = a;
      5'b???10: x = {ctl.rrx_in, a[word_w-1:1]};  // rrx feeds bit 31 here
      5'b??100: x = {a[1:0], a[word_w-1:2]};
      5'b?1000: x = {a[2:0], a[word_w-1:3]};
      5'b10000: x = {a[3:0], a[word_w-1:4]};
      default:  x = a;
    endcase
  end

  // second rank: ror by multiples of 4
  always_comb begin
    casez (ctl.shctl_8)
      8'b???????1: rot = x;
      8'b??????10: rot = {x[3:0],  x[word_w-1:4]};
      8'b?????100: rot = {x[7:0],  x[word_w-1:8]};
      8'b????1000: rot = {x[11:0], x[word_w-1:12]};
      8'b???10000: rot = {x[15:0], x[word_w-1:16]};
      8'b??100000: rot = {x[19:0], x[word_w-1:20]};
      8'b?1000000: rot = {x[23:0], x[word_w-1:24]};
      8'b10000000: rot = {x[27:0], x[word_w-1:28]};
      default:     rot = x;
    endcase
  end

  always_comb begin
    rw_d.valid     = ctl.valid;
    rw_d.rot       = rot;
    rw_d.a31       = a[word_w-1];   // sign for asr fill
    rw_d.shamt     = ctl.shamt;
    rw_d.longshift = ctl.longshift;
    rw_d.left      = ctl.left;
    rw_d.shift     = ctl.shift;
    rw_d.arith     = ctl.arith;
    // carry candidates, picked in stage 3
    rw_d.a0        = a[0];
    rw_d.rot0      = rot[0];
    rw_d.rot31     = rot[word_w-1];
    rw_d.carry_src = ctl.carry_src;
    rw_d.c_in      = ctl.c_in;
  end

  always_ff @(posedge clk) begin
    rw <= rw_d;
    if (reset) begin
      rw.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- shift_mask.sv
// ====================
// stage 3 of the shifter pipeline
// thermometer mask, zero or sign fill, carry-out select, result register
// ====================
`default_nettype none

module shift_mask (
  input  wire                       clk,
  input  wire                       reset,
  input  leg_shift_pkg::rot_word_t  rw,
  output leg_shift_pkg::shift_res_t res
);
  import leg_shift_pkg::*;

  logic [shamt_w:0]  n;       // 0..32 bits to kill, longshift on top
  logic [word_w-1:0] therm;   // top n bits set
  logic [word_w-1:0] mask;
  logic [word_w-1:0] kill;
  logic              fill;
  logic              c_sel;
  shift_res_t        res_d;

  assign n = {rw.longshift, rw.shamt};

  // thermometer from the msb, reversed for a left shift
  always_comb begin
    for (int i = 0; i < word_w; i++) begin
      therm[i] = (word_w - 1 - i) < int'(n);  // longshift sets every bit
    end
    for (int i = 0; i < word_w; i++) begin
      mask[i] = rw.left ? therm[word_w-1-i] : therm[i];
    end
  end

  assign fill = rw.arith & rw.a31;          // asr of a negative word
  assign kill = rw.shift ? mask : '0;       // rotates keep all bits

  // carry-out of the shifter
  always_comb begin
    unique case (rw.carry_src)
      c_keep:    c_sel = rw.c_in;
      src_a0:    c_sel = rw.a0;
      src_a31:   c_sel = rw.a31;
      src_rot0:  c_sel = rw.rot0;
      src_rot31: c_sel = rw.rot31;
      src_zero:  c_sel = 1'b0;
      default:   c_sel = rw.c_in;
    endcase
  end

  always_comb begin
    res_d.valid = rw.valid;
    res_d.y     = (rw.rot & ~kill) | ({word_w{fill}} & kill);
    res_d.c_out = c_sel;
  end

  always_ff @(posedge clk) begin
    res <= res_d;
    if (reset) begin
      res.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- shifter_pipe.sv
// ====================
// operand-2 shifter, three registered stages
// decode -> rotate -> mask
// ====================
`default_nettype none

module shifter_pipe (
  input  wire                       clk,
  input  wire                       reset,
  input  leg_shift_pkg::shift_op_t  op,    // one op per cycle, no stall
  output leg_shift_pkg::shift_res_t res    // op.valid + 3 cycles
);
  import leg_shift_pkg::*;

  shift_ctl_t ctl;   // decode -> rotate
  rot_word_t  rw;    // rotate -> mask

  // stage 1
  shift_decode u_decode (
    .clk   (clk),
    .reset (reset),
    .op    (op),
    .ctl   (ctl)
  );

  // stage 2
  barrel_shifter u_barrel (
    .clk   (clk),
    .reset (reset),
    .ctl   (ctl),
    .rw    (rw)
  );

  // stage 3
  shift_mask u_mask (
    .clk   (clk),
    .reset (reset),
    .rw    (rw),
    .res   (res)
  );

endmodule

`default_nettype wire

//--- shifter_pipe_tb.sv
// ====================
// testbench for the operand-2 shifter pipeline
// reference model, directed and random ops, scoreboard
// ====================
`default_nettype none

module shifter_pipe_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import leg_shift_pkg::*;

  typedef struct packed {
    logic [15:0] id;   // op number used in messages
    logic [31:0] y;
    logic        c;
  } exp_t;

  logic       clk = 1'b0;
  logic       reset;
  shift_op_t  op;
  shift_res_t res;

  exp_t   exp_q[$];     // expectations in issue order
  int     lat_q[$];     // cycle stamp of each op.valid seen
  int     cyc = 0;
  int     err_cnt = 0;
  int     op_cnt = 0;
  int     chk_cnt = 0;
  integer seed = 39591;
  exp_t   e_mon;
  int     st_mon;

  shifter_pipe DUT (
    .clk   (clk),
    .reset (reset),
    .op    (op),
    .res   (res)
  );

  always #4 clk = ~clk;  // 8 ns period

  // ARM shifter rules with fld as instr[11:4]
  function automatic exp_t ref_shift(input logic [31:0] a, input logic [7:0] fld,
                                     input logic [7:0] rs_amt, input logic c_in);
    exp_t        r;
    logic [1:0]  ty;
    logic [63:0] dbl;
    int          n;
    ty   = fld[2:1];
    r.id = '0;
    r.y  = a;
    r.c  = c_in;
    if (!fld[0]) begin
      n = int'(fld[7:3]);
      if (n == 0 && (ty == 2'd1 || ty == 2'd2)) n = 32;  // lsr/asr #0 mean 32
      if (n == 0 && ty == 2'd3) begin
        r.y = {c_in, a[31:1]};  // rrx
        r.c = a[0];
        return r;
      end
    end else begin
      n = int'(rs_amt);
      if (n != 0 && ty == 2'd3) begin
        n = n % 32;
        if (n == 0) begin
          r.c = a[31];  // ror by a multiple of 32
          return r;
        end
      end
    end
    if (n == 0) return r;  // value and carry kept
    case (ty)
      2'd0: begin
        r.y = (n >= 32) ? '0 : a << n;
        r.c = (n > 32) ? 1'b0 : a[5'(32 - n)];
      end
      2'd1: begin
        r.y = (n >= 32) ? '0 : a >> n;
        r.c = (n > 32) ? 1'b0 : ((n == 32) ? a[31] : a[5'(n - 1)]);
      end
      2'd2: begin
        if (n >= 32) begin
          r.y = {32{a[31]}};
        end else begin
          r.y = $signed(a) >>> n;  // sign copies in from the top
        end
        r.c = (n >= 32) ? a[31] : a[5'(n - 1)];
      end
      default: begin
        dbl = {a, a} >> n;
        r.y = dbl[31:0];
        r.c = a[5'(n - 1)];
      end
    endcase
    return r;
  endfunction

  function automatic logic [7:0] make_imm_field(input logic [1:0] ty, input logic [4:0] imm5);
    return {imm5, ty, 1'b0};
  endfunction

  function automatic logic [7:0] make_reg_field(input logic [1:0] ty, input logic [3:0] rs);
    return {rs, 1'b0, ty, 1'b1};  // bit 4 must stay clear
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // one op per rising edge with its expectation queued alongside
  task automatic send_op(input logic [31:0] a, input logic [7:0] fld,
                         input logic [7:0] amt, input logic c);
    shift_op_t o;
    exp_t      e;
    @(posedge clk);
    o.valid  = 1'b1;
    o.a      = a;
    o.field  = shift_field_u'(fld);
    o.rs_amt = amt;
    o.c_in   = c;
    op <= o;
    e    = ref_shift(a, fld, amt, c);
    e.id = 16'(op_cnt);
    exp_q.push_back(e);
    op_cnt++;
  endtask

  // drop valid, wait for the pipe to drain, report the test
  task automatic end_test(input string name, input int err0, input int ops0);
    int i;
    @(posedge clk);
    op.valid <= 1'b0;
    i = 0;
    while (exp_q.size() != 0 && i < 20) begin
      @(posedge clk);
      i++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d results of test %s never arrived", exp_q.size(), name);
      $display("Done: errors found");
      $finish;
    end else begin
      $display("test %s: %0d ops, %0d errors", name, op_cnt - ops0, err_cnt - err0);
    end
  endtask

  // compare on the falling edge where res is settled
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (!reset) begin
      if (res.valid !== 1'b0) begin
        if (exp_q.size() == 0 || lat_q.size() == 0) begin
          $display("result at %0t ns with no op in flight", $time);
          err_cnt++;
        end else begin
          e_mon  = exp_q.pop_front();
          st_mon = lat_q.pop_front();
          check_val($sformatf("op %0d latency", e_mon.id), 32'(cyc - st_mon), 32'd3);
          check_val($sformatf("op %0d y", e_mon.id), res.y, e_mon.y);
          check_val($sformatf("op %0d carry", e_mon.id), {31'b0, res.c_out}, {31'b0, e_mon.c});
          chk_cnt++;
        end
      end
      if (op.valid) lat_q.push_back(cyc);  // stamp for the latency check
    end
  end

  initial begin
    logic [31:0] pats [5];
    logic [7:0]  amts [6];
    logic [31:0] r;
    logic [31:0] a_r;
    logic [7:0]  amt;
    int          err0;
    int          ops0;
    pats  = '{32'h8000_0001, 32'hF0F0_1234, 32'h7FFF_FFFE, 32'hDEAD_BEEF, 32'h0000_0001};
    amts  = '{8'd0, 8'd1, 8'd31, 8'd32, 8'd33, 8'd255};
    reset = 1'b1;
    op    = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // res.valid stays low while idle before the single op
    err0 = err_cnt;
    ops0 = op_cnt;
    repeat (6) @(posedge clk);
    send_op(32'h8000_0001, make_imm_field(2'd0, 5'd4), 8'd0, 1'b0);
    end_test("reset_latency", err0, ops0);

    err0 = err_cnt;
    ops0 = op_cnt;
    foreach (pats[p])
      for (int t = 0; t < 4; t++)
        for (int n = 1; n < 32; n++)
          send_op(pats[p], make_imm_field(2'(t), 5'(n)), 8'd0, 1'((n + p) % 2));
    end_test("imm_normal", err0, ops0);

    // #0 forms with both carry-in values
    err0 = err_cnt;
    ops0 = op_cnt;
    foreach (pats[p])
      for (int t = 0; t < 4; t++) begin
        send_op(pats[p], make_imm_field(2'(t), 5'd0), 8'd0, 1'b0);
        send_op(pats[p], make_imm_field(2'(t), 5'd0), 8'd0, 1'b1);
      end
    end_test("imm_special", err0, ops0);

    err0 = err_cnt;
    ops0 = op_cnt;
    foreach (pats[p])
      foreach (amts[k])
        for (int t = 0; t < 4; t++) begin
          send_op(pats[p], make_reg_field(2'(t), 4'(k + 3)), amts[k], 1'b0);
          send_op(pats[p], make_reg_field(2'(t), 4'(k + 3)), amts[k], 1'b1);
        end
    end_test("reg_amounts", err0, ops0);

    // back to back with valid high every cycle
    err0 = err_cnt;
    ops0 = op_cnt;
    for (int j = 0; j < 300; j++) begin
      r   = $random(seed);
      a_r = $random(seed);
      amt = r[23:16];
      if (r[24]) amt = amt & 8'h3f;  // lands near 32 more often
      if (r[2]) begin
        send_op(a_r, make_reg_field(r[1:0], r[12:9]), amt, r[3]);
      end else begin
        send_op(a_r, make_imm_field(r[1:0], r[8:4]), amt, r[3]);
      end
    end
    end_test("random", err0, ops0);

    repeat (4) @(posedge clk);  // room for a stray result to show up
    $display("checked %0d of %0d ops, %0d errors", chk_cnt, op_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- shifter_pipe.f
leg_shift_pkg.sv
shift_decode.sv
barrel_shifter.sv
shift_mask.sv
shifter_pipe.sv
shifter_pipe_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = shifter_pipe_tb
FILELIST  = shifter_pipe.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = Done: no errors

SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
